// ==== Bender.yml ====
package:
  name: data_quant

sources:
  - include_dirs:
      - .
    files:
      - dq_sample_pkg.sv
      - dq_report_pkg.sv
      - dq_stream_if.sv
      - spike_filter.sv
      - extrema_tracker.sv
      - window_report.sv
      - data_quant.sv
  - target: test
    files:
      - dq_checker.sv
      - tb_data_quant.sv

// ==== data_quant.sv ====
`timescale 1ns/1ps
`default_nettype none

// adc sample conditioning
// spike filter, then window statistics, then held report
module data_quant import dq_sample_pkg::*, dq_report_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       sample_valid,
    input  sample_t    sample_data,
    output stat_code_t min,
    output stat_code_t max,
    output cross_cnt_t crossings,
    output spike_cnt_t spikes,
    output logic       result_valid
);

    // filtered samples into the tracker
    dq_stream_if #(.payload_t(filt_sample_t)) s1_if ();
    // one beat per window into the reporter
    dq_stream_if #(.payload_t(win_stats_t))   s2_if ();

    spike_filter u_spike_filter (
        .clk      (clk),
        .rst      (rst),
        .in_valid (sample_valid),
        .in_data  (sample_data),
        .out      (s1_if.src)
    );

    extrema_tracker u_extrema_tracker (
        .clk (clk),
        .rst (rst),
        .in  (s1_if.dst),
        .out (s2_if.src)
    );

    window_report u_window_report (
        .clk          (clk),
        .rst          (rst),
        .in           (s2_if.dst),
        .min          (min),
        .max          (max),
        .crossings    (crossings),
        .spikes       (spikes),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

// ==== dq_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// watches the report outputs and compares each window result
// samples on the falling edge where all outputs are settled
module dq_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  min,
    input  logic [7:0]  max,
    input  logic [9:0]  crossings,
    input  logic [7:0]  spikes,
    input  logic        result_valid,
    input  logic        exp_push,
    input  logic [33:0] exp_data,
    output int          error_count,
    output int          result_count
);

    // expected {min, max, crossings, spikes} in window order
    logic [33:0] pending [$];
    logic [33:0] expected;
    // value the held outputs must show between strobes
    logic [33:0] held;

    initial begin
        error_count  = 0;
        result_count = 0;
        // outputs read zero until the first report
        held         = '0;
    end

    task automatic compare_field(input string name, input logic [9:0] want,
                                 input logic [9:0] got);
        if (got !== want) begin
            $display("Error: %s expected 0x%h actual 0x%h at %0d ns", name, want, got, $time);
            error_count++;
        end
    endtask

    always @(negedge clk) begin
        if (exp_push) begin
            pending.push_back(exp_data);
        end
        if (!rst && result_valid !== 1'b0) begin
            compare_field("result_valid", 10'h000, {9'h000, result_valid});
        end
        // outputs keep the last window until the next strobe
        if (result_valid !== 1'b1) begin
            compare_field("min", {2'b00, held[33:26]}, {2'b00, min});
            compare_field("max", {2'b00, held[25:18]}, {2'b00, max});
            compare_field("crossings", held[17:8], crossings);
            compare_field("spikes", {2'b00, held[7:0]}, {2'b00, spikes});
        end
        if (rst && result_valid === 1'b1) begin
            if (pending.size() == 0) begin
                $display("a result arrived at %0d ns with no window left to check", $time);
                error_count++;
            end else begin
                expected = pending.pop_front();
                compare_field("min", {2'b00, expected[33:26]}, {2'b00, min});
                compare_field("max", {2'b00, expected[25:18]}, {2'b00, max});
                compare_field("crossings", expected[17:8], crossings);
                compare_field("spikes", {2'b00, expected[7:0]}, {2'b00, spikes});
                held = expected;
            end
            result_count++;
        end
    end

endmodule

`default_nettype wire

// ==== dq_defines.svh ====
`ifndef DQ_DEFINES_SVH
`define DQ_DEFINES_SVH

// filtered samples per measurement window
`define DQ_WIN_LEN 64

// mid-scale code of the adc
`define DQ_MID 128

// a spike must stand out from both neighbours by more than this
`define DQ_SPIKE_STEP 24

// largest distance from mid-scale after clipping
`define DQ_CLIP_SPAN 100

// extra room given to the positive excursion when accepting a new max
`define DQ_MAX_SLACK 4

// max may exceed the mirrored min by this much before it is corrected
`define DQ_ASYM_MARGIN 5

`endif

// ==== dq_report_pkg.sv ====
`default_nettype none

package dq_report_pkg;

    // code width of the reported min and max
    typedef logic [7:0] stat_code_t;
    // mid-scale crossings per window
    typedef logic [9:0] cross_cnt_t;
    // spikes removed per window
    typedef logic [7:0] spike_cnt_t;

    // statistics of one window in 34 bits
    typedef struct packed {
        stat_code_t min_code;
        stat_code_t max_code;
        cross_cnt_t crossings;
        spike_cnt_t spikes;
    } win_stats_t;

    localparam int WIN_STATS_W = $bits(win_stats_t);

endpackage

`default_nettype wire

// ==== dq_sample_pkg.sv ====
`default_nettype none

package dq_sample_pkg;

    // unsigned raw adc code centred on mid-scale
    typedef logic [7:0] sample_t;

    // sample after the spike filter
    // spike marks a replaced sample
    // clip marks a sample pulled back into range
    typedef struct packed {
        sample_t value;
        logic    spike;
        logic    clip;
    } filt_sample_t;

    // payload width of stage 1 in bits
    localparam int FILT_SAMPLE_W = $bits(filt_sample_t);

endpackage

`default_nettype wire

// ==== dq_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// valid-only stream between pipeline stages
// a beat is taken on every rising clk with valid high
interface dq_stream_if #(
    parameter type payload_t = logic [7:0]
);

    logic     valid;
    payload_t data;

    // producing stage
    modport src (
        output valid,
        output data
    );

    // consuming stage
    modport dst (
        input valid,
        input data
    );

endinterface

`default_nettype wire

// ==== dq_tests.txt ====
# kind amp half spike_int spike_h gap | exp_min exp_max exp_crossings exp_spikes, all hex
# kind 0 const, 1 triangle, 2 asym triangle, 3 asym from rising edge; gap masks lfsr idles
0 00 00 00 00 0  80 80 000 00
1 3C 08 00 00 0  44 BC 009 00
1 3C 08 10 50 0  44 BC 008 04
1 78 10 00 00 0  1C E4 004 00
2 50 08 00 00 0  6C 94 008 00
3 50 08 00 00 0  6C 94 009 00
1 3C 08 00 00 3  44 BC 009 00
1 3C 08 10 50 3  44 BC 008 04
0 00 00 00 00 1  80 80 001 00

// ==== extrema_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dq_defines.svh"

// stage 2
// gathers min, gated max, crossings and spikes over one window
module extrema_tracker import dq_sample_pkg::*, dq_report_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    dq_stream_if.dst in,
    dq_stream_if.src out
);

    localparam int         CNT_W = $clog2(`DQ_WIN_LEN + 1);
    localparam logic [8:0] MID9  = 9'(`DQ_MID);
    localparam logic [8:0] SLACK = 9'(`DQ_MAX_SLACK);

    logic [CNT_W-1:0] cnt;
    stat_code_t       run_min;
    stat_code_t       run_max;
    cross_cnt_t       run_cross;
    spike_cnt_t       run_spk;
    // previous sample lay at or above mid-scale
    logic             prev_side;
    logic             side_known;

    sample_t          d;
    logic             side;
    logic [8:0]       d_dist;
    logic [8:0]       min_dist;
    logic             accept;
    logic             last;
    win_stats_t       nxt;

    always_comb begin
        d        = in.data.value;
        side     = ({1'b0, d} >= MID9);
        d_dist   = side ? ({1'b0, d} - MID9) : (MID9 - {1'b0, d});
        min_dist = MID9 - {1'b0, run_min};
        // new max only if it stays near the mirror of the min
        accept   = ({1'b0, run_min} > MID9) || (d_dist < min_dist + SLACK);
        last     = (cnt == CNT_W'(`DQ_WIN_LEN - 1));

        nxt.min_code  = run_min;
        nxt.max_code  = run_max;
        if (d < run_min) begin
            nxt.min_code = d;
        end else if ((d > run_max) && accept) begin
            nxt.max_code = d;
        end
        nxt.crossings = run_cross;
        if (side_known && (side != prev_side)) begin
            nxt.crossings = run_cross + cross_cnt_t'(1);
        end
        nxt.spikes = run_spk + spike_cnt_t'(in.data.spike);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt        <= '0;
            run_min    <= 8'hff;
            run_max    <= 8'h00;
            run_cross  <= '0;
            run_spk    <= '0;
            prev_side  <= 1'b0;
            side_known <= 1'b0;
            out.valid  <= 1'b0;
        end else begin
            out.valid <= in.valid && last;
            if (in.valid) begin
                // side history runs across window boundaries
                prev_side  <= side;
                side_known <= 1'b1;
                if (last) begin
                    cnt       <= '0;
                    run_min   <= 8'hff;
                    run_max   <= 8'h00;
                    run_cross <= '0;
                    run_spk   <= '0;
                end else begin
                    cnt       <= cnt + CNT_W'(1);
                    run_min   <= nxt.min_code;
                    run_max   <= nxt.max_code;
                    run_cross <= nxt.crossings;
                    run_spk   <= nxt.spikes;
                end
            end
        end
    end

    // window result includes the closing sample
    always_ff @(posedge clk) begin
        if (in.valid && last) begin
            out.data <= nxt;
        end
    end

endmodule

`default_nettype wire

// ==== spike_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dq_defines.svh"

// stage 1
// removes isolated spikes and clips around mid-scale
// output lags the input by one accepted sample
module spike_filter import dq_sample_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  sample_t        in_data,
    dq_stream_if.src       out
);

    localparam logic [8:0] STEP    = 9'(`DQ_SPIKE_STEP);
    localparam sample_t    CLIP_HI = sample_t'(`DQ_MID + `DQ_CLIP_SPAN);
    localparam sample_t    CLIP_LO = sample_t'(`DQ_MID - `DQ_CLIP_SPAN);

    // sample n-2 and sample n-1
    sample_t      hist_left;
    sample_t      hist_mid;
    // saturates at 2 once both history slots are valid
    logic [1:0]   fill;

    logic         spike_hi;
    logic         spike_lo;
    logic         is_spike;
    logic [8:0]   pair_sum;
    sample_t      fixed;
    filt_sample_t filt;

    always_comb begin
        // middle sample stands above both neighbours
        spike_hi = ({1'b0, hist_mid} > {1'b0, hist_left} + STEP) &&
                   ({1'b0, hist_mid} > {1'b0, in_data} + STEP);
        // or sits below both
        spike_lo = ({1'b0, hist_mid} + STEP < {1'b0, hist_left}) &&
                   ({1'b0, hist_mid} + STEP < {1'b0, in_data});
        is_spike = spike_hi || spike_lo;
        // mean of the neighbours, rounded down
        pair_sum = {1'b0, hist_left} + {1'b0, in_data};
        fixed    = is_spike ? pair_sum[8:1] : hist_mid;

        filt.spike = is_spike;
        filt.clip  = 1'b0;
        filt.value = fixed;
        if (fixed > CLIP_HI) begin
            filt.value = CLIP_HI;
            filt.clip  = 1'b1;
        end else if (fixed < CLIP_LO) begin
            filt.value = CLIP_LO;
            filt.clip  = 1'b1;
        end
    end

    // sample history shifts only on accepted input
    always_ff @(posedge clk) begin
        if (in_valid) begin
            hist_left <= hist_mid;
            hist_mid  <= in_data;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fill      <= 2'd0;
            out.valid <= 1'b0;
        end else begin
            // first two samples only prime the history
            out.valid <= in_valid && (fill == 2'd2);
            if (in_valid && (fill != 2'd2)) begin
                fill <= fill + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && (fill == 2'd2)) begin
            out.data <= filt;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
dq_sample_pkg.sv
dq_report_pkg.sv
dq_stream_if.sv
spike_filter.sv
extrema_tracker.sv
window_report.sv
data_quant.sv
dq_checker.sv
tb_data_quant.sv

// ==== tb_data_quant.sv ====
`timescale 1ns/1ps
`default_nettype none

// testbench top for the adc conditioning pipeline
module tb_data_quant;

    localparam int WIN_LEN        = 64;
    localparam int MID            = 128;
    localparam int RESULT_TIMEOUT = 500;

    logic        clk;
    logic        rst;
    logic        sample_valid;
    logic [7:0]  sample_data;
    logic [7:0]  min;
    logic [7:0]  max;
    logic [9:0]  crossings;
    logic [7:0]  spikes;
    logic        result_valid;
    // expected window results handed to the checker
    logic        exp_push;
    logic [33:0] exp_data;
    int          error_count;
    int          result_count;
    int          timeouts;
    int          windows;
    logic [31:0] lfsr;

    data_quant UUT (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .min          (min),
        .max          (max),
        .crossings    (crossings),
        .spikes       (spikes),
        .result_valid (result_valid)
    );

    dq_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .min          (min),
        .max          (max),
        .crossings    (crossings),
        .spikes       (spikes),
        .result_valid (result_valid),
        .exp_push     (exp_push),
        .exp_data     (exp_data),
        .error_count  (error_count),
        .result_count (result_count)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // sample idx of one window
    // kind 0 constant at mid+amp, 1 triangle, 2 triangle with a quarter-size
    // negative half, 3 same as 2 but starting just above mid on the rising edge
    function automatic int wave_sample(input int kind, input int amp, input int half,
                                       input int spk_int, input int spk_h, input int idx);
        int p;
        int v;
        if (kind == 0) begin
            v = MID + amp;
        end else begin
            p = (kind == 3) ? (idx + half / 2 + 1) % (2 * half) : idx % (2 * half);
            if (p < half) begin
                v = MID - amp + (2 * amp * p) / half;
            end else begin
                v = MID + amp - (2 * amp * (p - half)) / half;
            end
            if (kind >= 2 && v < MID) begin
                v = MID - (MID - v) / 4;
            end
        end
        // isolated spike a quarter into each spike interval
        if (spk_int != 0 && idx % spk_int == spk_int / 4) begin
            v = v + spk_h;
        end
        // adc saturates at the code range
        if (v > 255) begin
            v = 255;
        end else if (v < 0) begin
            v = 0;
        end
        return v;
    endfunction

    // idle cycles before the sample come from lfsr bits masked by gap
    task automatic send_sample(input int v, input int gap);
        logic [1:0] idle;
        int         b;
        idle = 2'b00;
        if (gap != 0) begin
            for (b = 0; b < 2; b++) begin
                lfsr = lfsr_step(lfsr);
                idle = {idle[0], lfsr[0]};
            end
            idle = idle & gap[1:0];
        end
        for (b = 0; b < idle; b++) begin
            @(posedge clk);
            sample_valid <= 1'b0;
            exp_push     <= 1'b0;
        end
        @(posedge clk);
        sample_valid <= 1'b1;
        sample_data  <= v[7:0];
        exp_push     <= 1'b0;
    endtask

    // the last window reports a few clocks after the trailing sample
    task automatic wait_results(input int n);
        int t;
        t = 0;
        while (result_count < n && t < RESULT_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (result_count < n) begin
            $display("Timeout: no result arrived for window %0d within %0d cycles",
                     result_count + 1, RESULT_TIMEOUT);
            timeouts++;
        end
    endtask

    initial begin
        int               fd;
        int               n;
        int               i;
        int               kind;
        int               amp;
        int               half;
        int               spk_int;
        int               spk_h;
        int               gap;
        int               e_min;
        int               e_max;
        int               e_cross;
        int               e_spk;
        logic [8*128-1:0] line;
        clk          = 1'b0;
        rst          = 1'b0;
        sample_valid = 1'b0;
        sample_data  = 8'h00;
        exp_push     = 1'b0;
        exp_data     = '0;
        timeouts     = 0;
        windows      = 0;
        lfsr         = 32'hacff_f763;
        repeat (8) @(posedge clk);
        rst <= 1'b1;

        fd = $fopen("dq_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open dq_tests.txt so no stimulus was applied");
        end else begin
            // lead-in sample primes the filter history so windows line up
            send_sample(MID, 0);
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", kind, amp, half,
                            spk_int, spk_h, gap, e_min, e_max, e_cross, e_spk);
                if (n == 10) begin
                    for (i = 0; i < WIN_LEN; i++) begin
                        send_sample(wave_sample(kind, amp, half, spk_int, spk_h, i), gap);
                        if (i == 0) begin
                            exp_push <= 1'b1;
                            exp_data <= {e_min[7:0], e_max[7:0], e_cross[9:0], e_spk[7:0]};
                        end
                    end
                    windows++;
                end
            end
            $fclose(fd);
            // trailing sample lets the filter release the last window sample
            send_sample(MID, 0);
            @(posedge clk);
            sample_valid <= 1'b0;
        end

        wait_results(windows);
        // catch any extra result strobe
        repeat (8) @(negedge clk);
        if (windows == 0) begin
            $display("no test windows were read from dq_tests.txt");
        end
        $display("mismatches %0d timeouts %0d windows %0d results %0d",
                 error_count, timeouts, windows, result_count);
        if (error_count == 0 && timeouts == 0 && windows > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== window_report.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dq_defines.svh"

// stage 3
// mirrors an oversized max and holds the results between windows
module window_report import dq_report_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    dq_stream_if.dst   in,
    output stat_code_t min,
    output stat_code_t max,
    output cross_cnt_t crossings,
    output spike_cnt_t spikes,
    output logic       result_valid
);

    localparam logic [8:0] MID9   = 9'(`DQ_MID);
    localparam logic [8:0] MARGIN = 9'(`DQ_ASYM_MARGIN);

    logic [8:0] max_dist;
    logic [8:0] min_dist;
    logic       mirror;
    stat_code_t max_fixed;

    always_comb begin
        max_dist  = {1'b0, in.data.max_code} - MID9;
        min_dist  = MID9 - {1'b0, in.data.min_code};
        // only when the window straddles mid-scale
        mirror    = ({1'b0, in.data.max_code} > MID9) &&
                    ({1'b0, in.data.min_code} < MID9) &&
                    (max_dist > min_dist + MARGIN);
        max_fixed = mirror ? stat_code_t'(MID9 + min_dist) : in.data.max_code;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            min          <= '0;
            max          <= '0;
            crossings    <= '0;
            spikes       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= in.valid;
            if (in.valid) begin
                min       <= in.data.min_code;
                max       <= max_fixed;
                crossings <= in.data.crossings;
                spikes    <= in.data.spikes;
            end
        end
    end

endmodule

`default_nettype wire
